//--- files.f
+incdir+common
common/uart_pkg.sv
common/uart_ctrl_if.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
bench/uart_tb.sv

//--- Makefile
# Verilator build and run for the UART testbench

VERILATOR  ?= verilator
TOP        ?= uart_tb
RTL_TOP    ?= uart_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+common common/uart_pkg.sv common/uart_ctrl_if.sv \
		uart_tx/uart_tx.sv uart_rx/uart_rx.sv hdl/uart_regs.sv hdl/uart_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

   localparam int MAX_DIV        = 16;  // slowest divisor used
   localparam int N_BYTES        = 20;
   localparam int TIMEOUT_CYCLES = N_BYTES * 12 * MAX_DIV * 2 + 2000;

   logic                 clk = 1'b0;
   logic                 rst_int;
   logic                 valid;
   uart_pkg::reg_addr_e  address;
   uart_pkg::data_word_t wdata;
   logic                 wstrb;
   uart_pkg::data_word_t rdata;
   logic                 ready;
   logic                 txd;
   logic                 rxd;
   logic                 cts;
   logic                 rts;
   logic                 loop_en;  // txd back into rxd
   integer               seed = 32'h9fb4;
   int                   cycles = 0;

   uart_top uart_top_i (
      .clk     (clk),
      .rst_int (rst_int),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready),
      .txd     (txd),
      .rxd     (rxd),
      .cts     (cts),
      .rts     (rts)
   );

   assign rxd = loop_en ? txd : 1'b1;

   always #5 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Verification failed");
         $fatal(1, "timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   //////////////////////////////
   // reference and compares
   //////////////////////////////

   // start bit first, data lsb first, stop bit last
   function automatic logic [9:0] expected_frame(input uart_pkg::uart_byte_t b);
      logic [9:0]           f;
      uart_pkg::uart_byte_t rest;
      int                   i;
      f    = '0;
      rest = b;
      for (i = 1; i <= 8; i++) begin
         f    = f | (10'(rest[0]) << i);
         rest = rest >> 1;
      end
      f = f | 10'h200;  // stop bit
      return f;
   endfunction

   task automatic check_word(input string name, input uart_pkg::data_word_t got,
                             input uart_pkg::data_word_t exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%0h exp 0x%0h", name, got, exp);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%0h exp 0x%0h", name, got, exp);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   //////////////////////////////
   // bus access
   //////////////////////////////
   task automatic bus_write(input uart_pkg::reg_addr_e addr, input uart_pkg::data_word_t data);
      @(negedge clk);
      check_bit("ready", ready, 1'b0);
      valid   = 1'b1;
      wstrb   = 1'b1;
      address = addr;
      wdata   = data;
      @(negedge clk);
      check_bit("ready", ready, 1'b1);  // one cycle after valid
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   task automatic bus_read(input uart_pkg::reg_addr_e addr, output uart_pkg::data_word_t data);
      @(negedge clk);
      check_bit("ready", ready, 1'b0);
      check_word("rdata", rdata, '0);  // idle bus reads zero
      valid   = 1'b1;
      wstrb   = 1'b0;
      address = addr;
      @(negedge clk);
      check_bit("ready", ready, 1'b1);
      data  = rdata;
      valid = 1'b0;
   endtask

   task automatic read_expect(input uart_pkg::reg_addr_e addr, input uart_pkg::data_word_t exp,
                              input string name);
      uart_pkg::data_word_t d;
      bus_read(addr, d);
      check_word(name, d, exp);
   endtask

   task automatic wait_tx_idle();
      uart_pkg::data_word_t d;
      do bus_read(uart_pkg::ADDR_WRITE_WAIT, d); while (d[0]);
   endtask

   task automatic wait_rx_valid();
      uart_pkg::data_word_t d;
      do bus_read(uart_pkg::ADDR_READ_VALID, d); while (!d[0]);
   endtask

   // sample txd at every bit centre of one frame
   task automatic check_frame(input int div);
      uart_pkg::uart_byte_t b;
      logic [9:0]           exp;
      int                   t;
      int                   centre;
      int                   k;
      b      = uart_pkg::uart_byte_t'($random(seed));
      exp    = expected_frame(b);
      t      = 0;
      centre = div / 2;
      bus_write(uart_pkg::ADDR_DIV, uart_pkg::data_word_t'(div));
      bus_write(uart_pkg::ADDR_DATA, uart_pkg::data_word_t'(b));
      for (k = 0; k < 10; k++) begin
         while (t < centre) begin
            @(negedge clk);
            t++;
         end
         check_bit("txd", txd, exp[0]);
         exp    = exp >> 1;
         centre = centre + div;
      end
      wait_tx_idle();
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin
      uart_pkg::uart_byte_t b;
      rst_int = 1'b1;
      valid   = 1'b0;
      address = uart_pkg::ADDR_WRITE_WAIT;
      wdata   = '0;
      wstrb   = 1'b0;
      cts     = 1'b1;
      loop_en = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_int = 1'b0;

      // reset values
      check_bit("txd", txd, 1'b1);
      check_bit("rts", rts, 1'b0);
      check_bit("ready", ready, 1'b0);
      read_expect(uart_pkg::ADDR_DIV, 32'd1, "div");
      read_expect(uart_pkg::ADDR_READ_VALID, 32'd0, "read_valid");

      // register readback
      bus_write(uart_pkg::ADDR_DIV, 32'd8);
      read_expect(uart_pkg::ADDR_DIV, 32'd8, "div");
      bus_write(uart_pkg::ADDR_DIV, 32'd13);
      read_expect(uart_pkg::ADDR_DIV, 32'd13, "div");
      bus_write(uart_pkg::ADDR_RXEN, 32'd1);
      check_bit("rts", rts, 1'b1);

      // frame shape with the receiver kept quiet
      loop_en = 1'b0;
      bus_write(uart_pkg::ADDR_TXEN, 32'd1);
      check_frame(4);
      check_frame(7);
      check_frame(MAX_DIV);
      bus_write(uart_pkg::ADDR_TXEN, 32'd0);
      bus_write(uart_pkg::ADDR_DATA, 32'h55);
      repeat (10 * MAX_DIV) begin
         @(negedge clk);
         check_bit("txd", txd, 1'b1);  // disabled line stays idle
      end
      wait_tx_idle();
      loop_en = 1'b1;

      // loopback receive
      bus_write(uart_pkg::ADDR_DIV, 32'd8);
      bus_write(uart_pkg::ADDR_TXEN, 32'd1);
      repeat (16) begin
         b = uart_pkg::uart_byte_t'($random(seed));
         bus_write(uart_pkg::ADDR_DATA, uart_pkg::data_word_t'(b));
         wait_rx_valid();
         read_expect(uart_pkg::ADDR_DATA, uart_pkg::data_word_t'(b), "rx_data");
         wait_tx_idle();
      end
      read_expect(uart_pkg::ADDR_READ_VALID, 32'd0, "read_valid");

      // wait flag
      b = uart_pkg::uart_byte_t'($random(seed));
      bus_write(uart_pkg::ADDR_DATA, uart_pkg::data_word_t'(b));
      read_expect(uart_pkg::ADDR_WRITE_WAIT, 32'd1, "write_wait");
      wait_tx_idle();
      read_expect(uart_pkg::ADDR_WRITE_WAIT, 32'd0, "write_wait");
      cts = 1'b0;
      @(negedge clk);
      read_expect(uart_pkg::ADDR_WRITE_WAIT, 32'd1, "write_wait");
      cts = 1'b1;
      repeat (3) @(negedge clk);  // let the synchronizer settle

      // soft reset
      bus_write(uart_pkg::ADDR_SOFT_RESET, 32'd1);
      @(negedge clk);
      check_bit("rts", rts, 1'b0);
      read_expect(uart_pkg::ADDR_DIV, 32'd1, "div");
      read_expect(uart_pkg::ADDR_READ_VALID, 32'd0, "read_valid");
      bus_write(uart_pkg::ADDR_DATA, 32'hA5);
      repeat (20) begin
         @(negedge clk);
         check_bit("txd", txd, 1'b1);
      end

      $display("Verification passed");
      $finish;
   end

endmodule

//--- hdl/uart_top.sv
`timescale 1ns/1ns

module uart_top (
   input  logic                  clk,
   input  logic                  rst_int,

   // cpu bus
   input  logic                  valid,
   input  uart_pkg::reg_addr_e   address,
   input  uart_pkg::data_word_t  wdata,
   input  logic                  wstrb,
   output uart_pkg::data_word_t  rdata,
   output logic                  ready,

   // serial lines
   output logic                  txd,
   input  logic                  rxd,
   input  logic                  cts,
   output logic                  rts
);

   logic tx_en;

   uart_ctrl_if ctrl_if ();

   uart_regs uart_regs_i (
      .clk     (clk),
      .rst_int (rst_int),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready),
      .cts     (cts),
      .rts     (rts),
      .tx_en   (tx_en),
      .ctrl    (ctrl_if.regs_mp)
   );

   uart_tx uart_tx_i (
      .clk   (clk),
      .tx_en (tx_en),
      .ctrl  (ctrl_if.tx_mp),
      .txd   (txd)
   );

   // runs whatever rx_en says
   uart_rx uart_rx_i (
      .clk  (clk),
      .rxd  (rxd),
      .ctrl (ctrl_if.rx_mp)
   );

endmodule

//--- hdl/uart_regs.sv
`timescale 1ns/1ns
`include "uart_params.svh"

module uart_regs (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  valid,
   input  uart_pkg::reg_addr_e   address,
   input  uart_pkg::data_word_t  wdata,
   input  logic                  wstrb,
   output uart_pkg::data_word_t  rdata,
   output logic                  ready,
   input  logic                  cts,
   output logic                  rts,
   output logic                  tx_en,
   uart_ctrl_if.regs_mp          ctrl
);

   logic                 line_rst;
   logic                 rst_soft;
   logic                 rx_en;
   uart_pkg::bit_div_t   bit_div;
   logic [1:0]           cts_sync;

   // registered bus command for the read phase
   uart_pkg::reg_addr_e  address_reg;
   logic                 wstrb_reg;

   // write decode strobes
   logic                 wr;
   logic                 div_we;
   logic                 soft_we;
   logic                 txen_we;
   logic                 rxen_we;

   assign wr      = valid & wstrb;
   assign div_we  = wr && (address == uart_pkg::ADDR_DIV);
   assign soft_we = wr && (address == uart_pkg::ADDR_SOFT_RESET);
   assign txen_we = wr && (address == uart_pkg::ADDR_TXEN);
   assign rxen_we = wr && (address == uart_pkg::ADDR_RXEN);

   //////////////////////////////
   // reset
   //////////////////////////////
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         rst_soft <= 1'b0;
      else
         rst_soft <= soft_we & wdata[0];  // single cycle pulse
   end

   assign line_rst = rst_int | rst_soft;

   //////////////////////////////
   // bus handshake
   //////////////////////////////
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         ready <= 1'b0;
      else
         ready <= valid;
   end

   always_ff @(posedge clk) begin
      address_reg <= address;
      wstrb_reg   <= wstrb;
   end

   // control registers
   always_ff @(posedge clk or posedge line_rst) begin
      if (line_rst) begin
         bit_div <= uart_pkg::bit_div_t'(1);
         tx_en   <= 1'b0;
         rx_en   <= 1'b0;
      end else begin
         if (div_we)
            bit_div <= wdata[`UART_DIV_W-1:0];
         if (txen_we)
            tx_en <= wdata[0];
         if (rxen_we)
            rx_en <= wdata[0];
      end
   end

   assign rts = rx_en;  // ready to receive

   // cts is asynchronous to clk
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int)
         cts_sync <= 2'b00;
      else
         cts_sync <= {cts_sync[0], cts};
   end

   //////////////////////////////
   // serial block strobes
   //////////////////////////////
   assign ctrl.line_rst = line_rst;
   assign ctrl.bit_div  = bit_div;
   assign ctrl.tx_load  = wr && (address == uart_pkg::ADDR_DATA);
   assign ctrl.tx_byte  = wdata[7:0];
   assign ctrl.rx_take  = valid && !wstrb && (address == uart_pkg::ADDR_DATA);

   // read data, zero unless a read is answered
   always_comb begin
      rdata = '0;
      if (ready && !wstrb_reg) begin
         case (address_reg)
            uart_pkg::ADDR_WRITE_WAIT: rdata[0] = ctrl.tx_busy | ~cts_sync[1];
            uart_pkg::ADDR_DIV:        rdata[`UART_DIV_W-1:0] = bit_div;
            uart_pkg::ADDR_DATA:       rdata[7:0] = ctrl.rx_byte;
            uart_pkg::ADDR_READ_VALID: rdata[0] = ctrl.rx_valid;
            default:                   rdata = '0;
         endcase
      end
   end

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
   input  logic        clk,
   input  logic        rxd,
   uart_ctrl_if.rx_mp  ctrl
);

   // sequencer states, 2..9 are the data samples
   localparam logic [3:0] ST_IDLE  = 4'd0;
   localparam logic [3:0] ST_HALF  = 4'd1;
   localparam logic [3:0] ST_FIRST = 4'd2;
   localparam logic [3:0] ST_STOP  = 4'd10;

   logic [3:0]           state;
   uart_pkg::bit_div_t   cnt;
   uart_pkg::bit_div_t   half;
   logic                 bit_done;
   logic                 sample;
   logic                 store;
   uart_pkg::uart_byte_t shift;
   uart_pkg::uart_byte_t buf_data;
   logic                 buf_valid;

   assign half     = ctrl.bit_div >> 1;
   assign bit_done = (cnt >= ctrl.bit_div);

   // data bit centre
   assign sample = bit_done && (state >= ST_FIRST) && (state < ST_STOP);
   // stop bit centre
   assign store  = bit_done && (state == ST_STOP);

   //////////////////////////////
   // sequencer
   //////////////////////////////
   always_ff @(posedge clk or posedge ctrl.line_rst) begin
      if (ctrl.line_rst) begin
         state     <= ST_IDLE;
         cnt       <= '0;
         buf_valid <= 1'b0;
      end else begin
         cnt <= cnt + 1'b1;
         if (ctrl.rx_take)
            buf_valid <= 1'b0;

         case (state)
            ST_IDLE: begin
               cnt <= uart_pkg::bit_div_t'(1);
               if (!rxd)  // start bit edge
                  state <= ST_HALF;
            end
            ST_HALF: begin
               // middle of the start bit
               if (cnt >= half) begin
                  state <= ST_FIRST;
                  cnt   <= uart_pkg::bit_div_t'(1);
               end
            end
            ST_STOP: begin
               if (bit_done) begin
                  state     <= ST_IDLE;
                  buf_valid <= 1'b1;  // new byte wins over a take
               end
            end
            default: begin
               if (bit_done) begin
                  state <= state + 1'b1;
                  cnt   <= uart_pkg::bit_div_t'(1);
               end
            end
         endcase
      end
   end

   // data path, lsb arrives first
   always_ff @(posedge clk) begin
      if (sample)
         shift <= {rxd, shift[7:1]};
      if (store)
         buf_data <= shift;  // overwrites an unread byte
   end

   assign ctrl.rx_byte  = buf_data;
   assign ctrl.rx_valid = buf_valid;

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
   input  logic        clk,
   input  logic        tx_en,
   uart_ctrl_if.tx_mp  ctrl,
   output logic        txd
);

   uart_pkg::bit_div_t rate_cnt;  // 1..bit_div within a bit
   logic [3:0]         bit_cnt;   // bits left in frame
   logic [9:0]         pattern;   // stop, data, start
   logic               bit_end;

   // last cycle of the current bit
   assign bit_end = (bit_cnt != 4'd0) && (rate_cnt == ctrl.bit_div);

   //////////////////////////////
   // bit-rate counter
   //////////////////////////////
   always_ff @(posedge clk or posedge ctrl.line_rst) begin
      if (ctrl.line_rst)
         rate_cnt <= '0;
      else if (ctrl.tx_load)
         rate_cnt <= uart_pkg::bit_div_t'(1);
      else if (bit_end)
         // stop counting once the stop bit is out
         rate_cnt <= (bit_cnt == 4'd1) ? '0 : uart_pkg::bit_div_t'(1);
      else if (bit_cnt != 4'd0)
         rate_cnt <= rate_cnt + 1'b1;
   end

   //////////////////////////////
   // bit counter
   //////////////////////////////
   always_ff @(posedge clk or posedge ctrl.line_rst) begin
      if (ctrl.line_rst)
         bit_cnt <= 4'd0;
      else if (ctrl.tx_load)
         bit_cnt <= 4'd10;  // start + 8 data + stop
      else if (bit_end)
         bit_cnt <= bit_cnt - 1'b1;
   end

   // shift register, ones fill in from the top
   always_ff @(posedge clk or posedge ctrl.line_rst) begin
      if (ctrl.line_rst)
         pattern <= '1;
      else if (ctrl.tx_load)
         pattern <= {1'b1, ctrl.tx_byte, 1'b0};
      else if (bit_end)
         pattern <= {1'b1, pattern[9:1]};
   end

   assign ctrl.tx_busy = (bit_cnt != 4'd0);

   // line idles high when disabled
   assign txd = pattern[0] | ~tx_en;

endmodule

//--- common/uart_ctrl_if.sv
`timescale 1ns/1ns

interface uart_ctrl_if;

   logic                  line_rst;  // hard or soft reset
   uart_pkg::bit_div_t    bit_div;

   // transmit side
   logic                  tx_load;
   uart_pkg::uart_byte_t  tx_byte;
   logic                  tx_busy;

   // receive side
   logic                  rx_take;
   uart_pkg::uart_byte_t  rx_byte;
   logic                  rx_valid;

   modport regs_mp (
      output line_rst, bit_div, tx_load, tx_byte, rx_take,
      input  tx_busy, rx_byte, rx_valid
   );

   modport tx_mp (
      input  line_rst, bit_div, tx_load, tx_byte,
      output tx_busy
   );

   modport rx_mp (
      input  line_rst, bit_div, rx_take,
      output rx_byte, rx_valid
   );

endinterface

//--- common/uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

   // cpu bus word
   typedef logic [`UART_DATA_W-1:0] data_word_t;

   // one serial character
   typedef logic [7:0] uart_byte_t;

   // bit period in clk cycles
   typedef logic [`UART_DIV_W-1:0] bit_div_t;

   //////////////////////////////
   // register map
   //////////////////////////////
   typedef enum logic [2:0] {
      ADDR_WRITE_WAIT = 3'd0,  // ro, tx busy or cts low
      ADDR_DIV        = 3'd1,  // rw
      ADDR_DATA       = 3'd2,  // wr sends, rd pops
      ADDR_READ_VALID = 3'd3,  // ro
      ADDR_SOFT_RESET = 3'd4,  // wo, bit 0
      ADDR_TXEN       = 3'd5,  // wo, bit 0
      ADDR_RXEN       = 3'd6   // wo, bit 0
   } reg_addr_e;

endpackage

//--- common/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// cpu side bus word
`define UART_DATA_W 32

// clock cycles per serial bit, counter width
`define UART_DIV_W 16

`endif
